/* hw/smul_pkg.sv */
`default_nettype none

package smul_pkg;

  //////////////////////////////////////////////////
  // row geometry
  //////////////////////////////////////////////////
  localparam int data_w     = 64;                 // data word, weight and packed result
  localparam int num_cells  = 4;                  // cells per row
  localparam int fwd_depth  = 2;                  // forward delay registers per cell
  localparam int cfg_addr_w = 3;                  // config address width

  localparam int lane8_n  = data_w / 8;           // int8 lanes per word
  localparam int lane16_n = data_w / 16;          // int16 lanes per word
  localparam int lane32_n = data_w / 32;          // int32 lanes per word

  // config address map
  localparam logic [cfg_addr_w-1:0] cfg_addr_prec = 3'd0;     // precision mode
  localparam logic [cfg_addr_w-1:0] cfg_addr_wgt0 = 3'd1;     // weight of cell 0
  localparam logic [cfg_addr_w-1:0] cfg_addr_max  = 3'd4;     // weight of last cell

  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1,
    prec_int32 = 2'd2                             // 2'd3 is illegal
  } prec_mode_e;

  typedef struct packed {
    prec_mode_e                            prec;  // shared by cells and tree
    logic [num_cells-1:0][data_w-1:0]      wgt;   // stationary weight per cell
  } smul_cfg_t;

  //////////////////////////////////////////////////
  // lane-wise arithmetic, low lane bits kept
  //////////////////////////////////////////////////
  function automatic logic [data_w-1:0] lane_mul(input logic [data_w-1:0] a,
                                                 input logic [data_w-1:0] b,
                                                 input prec_mode_e prec);
    logic [data_w-1:0] r;
    r = '0;
    case (prec)
      prec_int8:  for (int i = 0; i < lane8_n; i++)  r[i*8 +: 8]   = a[i*8 +: 8] * b[i*8 +: 8];
      prec_int16: for (int i = 0; i < lane16_n; i++) r[i*16 +: 16] = a[i*16 +: 16] * b[i*16 +: 16];
      prec_int32: for (int i = 0; i < lane32_n; i++) r[i*32 +: 32] = a[i*32 +: 32] * b[i*32 +: 32];
      default:    r = '0;                         // illegal mode gives zero
    endcase
    return r;
  endfunction

  function automatic logic [data_w-1:0] lane_add(input logic [data_w-1:0] a,
                                                 input logic [data_w-1:0] b,
                                                 input prec_mode_e prec);
    logic [data_w-1:0] r;
    r = '0;
    case (prec)                                   // no carry across lane edges
      prec_int8:  for (int i = 0; i < lane8_n; i++)  r[i*8 +: 8]   = a[i*8 +: 8] + b[i*8 +: 8];
      prec_int16: for (int i = 0; i < lane16_n; i++) r[i*16 +: 16] = a[i*16 +: 16] + b[i*16 +: 16];
      prec_int32: for (int i = 0; i < lane32_n; i++) r[i*32 +: 32] = a[i*32 +: 32] + b[i*32 +: 32];
      default:    r = '0;
    endcase
    return r;
  endfunction

endpackage

`default_nettype wire

/* hw/mac_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_config_regs
  import smul_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  cfg_we_i,     // write strobe, one word per cycle
  input  logic [cfg_addr_w-1:0] cfg_addr_i,   // 0 mode, 1..4 cell weights
  input  logic [data_w-1:0]     cfg_wdata_i,  // write data
  output smul_cfg_t             cfg_o         // mode and weights for the row
);

  smul_cfg_t cfg_d;
  smul_cfg_t cfg_q;

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////

  always_comb begin
    cfg_d = cfg_q;                                        // hold by default
    if (cfg_we_i) begin
      if (cfg_addr_i == cfg_addr_prec) begin
        if (cfg_wdata_i[1:0] != 2'd3) begin               // value 3 dropped
          cfg_d.prec = prec_mode_e'(cfg_wdata_i[1:0]);    // upper bits unused
        end
      end
      for (int k = 0; k < num_cells; k++) begin
        if (cfg_addr_i == cfg_addr_w'(cfg_addr_wgt0 + k)) begin
          cfg_d.wgt[k] = cfg_wdata_i;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_q.prec <= prec_int8;
      cfg_q.wgt  <= '0;
    end else begin
      cfg_q <= cfg_d;                                     // no enable gating here
    end
  end

  assign cfg_o = cfg_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_addr_range: assert property (
    @(posedge clk) disable iff (rst_i)
    cfg_we_i |-> (cfg_addr_i <= cfg_addr_max)
  ) else $error("mac_config_regs: write to unmapped address %0d", cfg_addr_i);

  a_mode_write: assert property (
    @(posedge clk) disable iff (rst_i)
    (cfg_we_i && cfg_addr_i == cfg_addr_prec) |-> (cfg_wdata_i[1:0] != 2'd3)
  ) else $error("mac_config_regs: illegal precision written");

  // the stored mode stays legal one cycle after any write sequence
  a_mode_held: assert property (
    @(posedge clk) disable iff (rst_i)
    1'b1 |=> (cfg_o.prec inside {prec_int8, prec_int16, prec_int32})
  ) else $error("mac_config_regs: stored precision illegal");

endmodule

`default_nettype wire

/* hw/smul_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module smul_cell
  import smul_pkg::*;
(
  input  logic              clk,
  input  logic              rst_i,
  input  logic              en_i,          // freezes product and forward regs when low
  input  prec_mode_e        prec_i,        // lane split of the word
  input  logic [data_w-1:0] weight_i,      // stationary weight of this cell
  input  logic [data_w-1:0] data_i,        // word from previous cell or row input
  output logic [data_w-1:0] prod_o,        // registered lane products
  output logic [data_w-1:0] data_fwd_o     // word delayed for the next cell
);

  //////////////////////////////////////////////////
  // product path
  //////////////////////////////////////////////////

  logic [data_w-1:0] prod_d;               // combinational lane products
  logic [data_w-1:0] prod_q;               // product register

  // one multiplier per lane, width set by the mode
  always_comb begin
    prod_d = lane_mul(data_i, weight_i, prec_i);
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      prod_q <= '0;
    end else if (en_i) begin
      prod_q <= prod_d;                    // latency of one enabled edge
    end
  end

  assign prod_o = prod_q;

  //////////////////////////////////////////////////
  // forward delay line
  //////////////////////////////////////////////////

  // the input word moves fwd_depth enabled edges before the next cell
  // sees it, so neighbouring cells work on words two apart
  logic [fwd_depth-1:0][data_w-1:0] fwd_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fwd_q <= '0;
    end else if (en_i) begin
      fwd_q[0] <= data_i;                  // first stage
      for (int i = 1; i < fwd_depth; i++) begin
        fwd_q[i] <= fwd_q[i-1];            // shift toward the output
      end
    end
  end

  assign data_fwd_o = fwd_q[fwd_depth-1];  // last stage leaves the cell

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the mode comes from the config block and must be legal whenever
  // the cell is computing
  a_prec_legal: assert property (
    @(posedge clk) disable iff (rst_i)
    en_i |-> (prec_i inside {prec_int8, prec_int16, prec_int32})
  ) else $error("smul_cell: illegal precision %0d while enabled", prec_i);

endmodule

`default_nettype wire

/* hw/lane_sum_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_sum_tree
  import smul_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             en_i,     // holds both stages when low
  input  prec_mode_e                       prec_i,   // lane split for the adders
  input  logic [num_cells-1:0][data_w-1:0] prod_i,   // products of all cells
  output logic [data_w-1:0]                sum_o     // packed lane-wise row sum
);

  localparam int pair_n = num_cells / 2;             // stage one adders

  //////////////////////////////////////////////////
  // stage one, adjacent pairs
  //////////////////////////////////////////////////

  logic [pair_n-1:0][data_w-1:0] pair_d;
  logic [pair_n-1:0][data_w-1:0] pair_q;

  always_comb begin
    for (int p = 0; p < pair_n; p++) begin
      pair_d[p] = lane_add(prod_i[2*p], prod_i[2*p+1], prec_i);  // 0+1 and 2+3
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pair_q <= '0;
    end else if (en_i) begin
      pair_q <= pair_d;
    end
  end

  //////////////////////////////////////////////////
  // stage two, final reduction
  //////////////////////////////////////////////////

  logic [data_w-1:0] sum_d;
  logic [data_w-1:0] sum_q;

  always_comb begin
    sum_d = lane_add(pair_q[0], pair_q[1], prec_i);  // each lane wraps
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sum_q <= '0;
    end else if (en_i) begin
      sum_q <= sum_d;
    end
  end

  assign sum_o = sum_q;

endmodule

`default_nettype wire

/* hw/smul_row.sv */
`timescale 1ns/1ps
`default_nettype none

module smul_row
  import smul_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  en_i,         // level enable for all data regs
  input  logic                  cfg_we_i,     // config write strobe
  input  logic [cfg_addr_w-1:0] cfg_addr_i,   // config address
  input  logic [data_w-1:0]     cfg_wdata_i,  // config data
  input  logic [data_w-1:0]     data_i,       // word entering cell 0
  output logic [data_w-1:0]     sum_o,        // lane-wise sum of all products
  output logic [data_w-1:0]     data_o        // word leaving the last cell
);

  smul_cfg_t                        cfg;      // mode and weights from the config block
  logic [num_cells:0][data_w-1:0]   chain;    // chain[k] feeds cell k, last entry leaves the row
  logic [num_cells-1:0][data_w-1:0] prod;     // registered products of all cells

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////

  mac_config_regs u_cfg (
    .clk         (clk),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg)
  );

  //////////////////////////////////////////////////
  // systolic cells
  //////////////////////////////////////////////////

  assign chain[0] = data_i;                   // row input enters cell 0

  for (genvar k = 0; k < num_cells; k++) begin : g_cell
    smul_cell u_cell (
      .clk        (clk),
      .rst_i      (rst_i),
      .en_i       (en_i),
      .prec_i     (cfg.prec),
      .weight_i   (cfg.wgt[k]),              // stationary weight of cell k
      .data_i     (chain[k]),
      .prod_o     (prod[k]),
      .data_fwd_o (chain[k+1])               // two enabled edges later at cell k+1
    );
  end

  assign data_o = chain[num_cells];           // chained to a next row

  //////////////////////////////////////////////////
  // reduction
  //////////////////////////////////////////////////

  lane_sum_tree u_tree (
    .clk    (clk),
    .rst_i  (rst_i),
    .en_i   (en_i),
    .prec_i (cfg.prec),
    .prod_i (prod),
    .sum_o  (sum_o)
  );

endmodule

`default_nettype wire

/* sim/smul_row_ref.svh */
`ifndef SMUL_ROW_REF_SVH
`define SMUL_ROW_REF_SVH

//////////////////////////////////////////////////
// reference model of the row arithmetic
//////////////////////////////////////////////////

// lane width in bits for a precision code
function automatic int lane_bits(input logic [1:0] prec);
  case (prec)
    2'd0:    return 8;                                 // eight int8 lanes
    2'd1:    return 16;                                // four int16 lanes
    default: return 32;                                // two int32 lanes
  endcase
endfunction

// multiply lane by lane, each product cut to the lane width
function automatic logic [data_w-1:0] mul_lanes(input logic [data_w-1:0] a,
                                                input logic [data_w-1:0] b,
                                                input int lw);
  logic [data_w-1:0] mask;
  logic [data_w-1:0] r;
  logic [data_w-1:0] pa;
  logic [data_w-1:0] pb;
  int                base;
  mask = (data_w'(1) << lw) - data_w'(1);              // low lw bits set
  r    = '0;
  for (base = 0; base < data_w; base += lw) begin
    pa = (a >> base) & mask;                           // operands zero extended
    pb = (b >> base) & mask;
    r  = r | (((pa * pb) & mask) << base);             // full product, then cut
  end
  return r;
endfunction

// add lane by lane, every lane wraps on its own
function automatic logic [data_w-1:0] add_lanes(input logic [data_w-1:0] a,
                                                input logic [data_w-1:0] b,
                                                input int lw);
  logic [data_w-1:0] mask;
  logic [data_w-1:0] r;
  int                base;
  mask = (data_w'(1) << lw) - data_w'(1);
  r    = '0;
  for (base = 0; base < data_w; base += lw) begin
    r = r | (((((a >> base) & mask) + ((b >> base) & mask)) & mask) << base);
  end
  return r;
endfunction

// expected sum_o after an edge, h[0] being the newest enabled word
function automatic logic [data_w-1:0] row_sum_model(input logic [8:0][data_w-1:0] h,
                                                    input logic [num_cells-1:0][data_w-1:0] w,
                                                    input int lw);
  logic [data_w-1:0] acc;
  int                k;
  acc = '0;
  for (k = 0; k < num_cells; k++) begin
    acc = add_lanes(acc, mul_lanes(h[2 + 2*k], w[k], lw), lw);  // cell k is 2k words behind
  end
  return acc;
endfunction

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

`endif

/* sim/smul_row_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module smul_row_tb
  import smul_pkg::*;
();

  `include "smul_row_ref.svh"

  //////////////////////////////////////////////////
  // run length
  //////////////////////////////////////////////////
  localparam int clk_ns      = 4;
  localparam int n_words     = 40;                     // words per precision phase
  localparam int n_idle      = 12;                     // words with zero weights
  localparam int max_stall   = 4;                      // longest en_i low stretch
  localparam int stim_cycles = 5 * 2                   // resets
                             + 4 * (num_cells + 1)     // config writes
                             + n_idle + 4 * n_words
                             + n_words * max_stall     // worst case stalls
                             + 4;                      // tail
  localparam int watchdog_ns = stim_cycles * clk_ns * 3 / 2;

  logic                  clk;
  logic                  rst_i;
  logic                  en_i;
  logic                  cfg_we_i;
  logic [cfg_addr_w-1:0] cfg_addr_i;
  logic [data_w-1:0]     cfg_wdata_i;
  logic [data_w-1:0]     data_i;
  logic [data_w-1:0]     sum_o;
  logic [data_w-1:0]     data_o;

  logic [31:0]                      lfsr;              // random source state
  logic [8:0][data_w-1:0]           hist;              // hist[0] newest enabled word
  logic [num_cells-1:0][data_w-1:0] wgt_model;         // weights as written
  logic [1:0]                       prec_model;        // mode as written
  logic                             held_edge;         // last edge had en_i low
  logic                             checks_on;
  logic [data_w-1:0]                prev_sum;
  logic [data_w-1:0]                prev_data;
  logic [data_w-1:0]                exp_sum;
  logic [data_w-1:0]                exp_data;
  int                               sum_errs;
  int                               data_errs;
  int                               hold_errs;
  int                               n_checks;

  smul_row UUT (
    .clk         (clk),
    .rst_i       (rst_i),
    .en_i        (en_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .data_i      (data_i),
    .sum_o       (sum_o),
    .data_o      (data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_ns / 2.0) clk = ~clk;                // 4 ns period
  end

  //////////////////////////////////////////////////
  // model state and checking
  //////////////////////////////////////////////////

  // tracks history and config on the same edges as the DUT
  always @(posedge clk) begin
    if (rst_i) begin
      hist       <= '0;                                // history counts as zeros
      wgt_model  <= '0;
      prec_model <= 2'd0;                              // int8 after reset
      held_edge  <= 1'b0;
    end else begin
      held_edge <= !en_i;
      if (en_i) begin
        hist <= {hist[7:0], data_i};                   // shift in sampled word
      end
      if (cfg_we_i) begin
        if (cfg_addr_i == 0 && cfg_wdata_i[1:0] != 2'd3) begin
          prec_model <= cfg_wdata_i[1:0];              // only two low bits kept
        end
        if (cfg_addr_i >= 1 && cfg_addr_i <= num_cells) begin
          wgt_model[cfg_addr_i - 1] <= cfg_wdata_i;
        end
      end
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (checks_on) begin
      exp_sum  = row_sum_model(hist, wgt_model, lane_bits(prec_model));
      exp_data = hist[7];                              // seven enabled edges back
      n_checks++;
      assert (sum_o === exp_sum) else begin
        $display("Fail at %0t: sum_o expected %h, got %h", $time, exp_sum, sum_o);
        sum_errs++;
      end
      assert (data_o === exp_data) else begin
        $display("Fail at %0t: data_o expected %h, got %h", $time, exp_data, data_o);
        data_errs++;
      end
      if (held_edge) begin
        assert (sum_o === prev_sum && data_o === prev_data) else begin
          $display("outputs changed at %0t although en_i was low", $time);
          hold_errs++;
        end
      end
    end
    prev_sum  = sum_o;
    prev_data = data_o;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #0.5;                                              // drive just after the edge
  endtask

  // one LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [data_w-1:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[data_w-2:0], lfsr[0]};
    end
  endtask

  task automatic apply_reset();
    rst_i    = 1'b1;
    en_i     = 1'b0;
    cfg_we_i = 1'b0;
    data_i   = '0;
    tick();
    tick();                                            // two cycles in reset
    rst_i = 1'b0;
  endtask

  task automatic write_cfg(input logic [cfg_addr_w-1:0] addr, input logic [data_w-1:0] wdata);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    tick();
  endtask

  // mode plus fresh random weights, data path frozen meanwhile
  task automatic configure(input logic [1:0] prec);
    logic [data_w-1:0] w;
    int                k;
    en_i   = 1'b0;
    data_i = '0;
    write_cfg(0, data_w'(prec));
    for (k = 0; k < num_cells; k++) begin
      draw_bits(data_w, w);
      write_cfg(cfg_addr_w'(k + 1), w);
    end
    cfg_we_i = 1'b0;
  endtask

  // random words, optionally with en_i low stretches of 1 to 4 cycles
  task automatic run_stream(input int n, input bit stalls, input logic [data_w-1:0] force_bits);
    logic [data_w-1:0] w;
    logic [data_w-1:0] s;
    int                i;
    int                j;
    for (i = 0; i < n; i++) begin
      draw_bits(data_w, w);
      data_i = w | force_bits;
      en_i   = 1'b1;
      tick();
      if (stalls) begin
        draw_bits(1, s);
        if (s[0]) begin
          draw_bits(2, s);
          for (j = 0; j <= int'(s[1:0]); j++) begin
            en_i = 1'b0;
            draw_bits(data_w, w);
            data_i = w;                                // must be ignored
            tick();
          end
        end
      end
    end
    en_i = 1'b0;
  endtask

  initial begin
    rst_i       = 1'b1;
    en_i        = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    data_i      = '0;
    lfsr        = 32'heef5119e;
    checks_on   = 1'b0;
    prev_sum    = '0;
    prev_data   = '0;
    sum_errs    = 0;
    data_errs   = 0;
    hold_errs   = 0;
    n_checks    = 0;
    repeat (2) @(posedge clk);
    #0.5;
    rst_i     = 1'b0;
    checks_on = 1'b1;

    run_stream(n_idle, 0, '0);                         // weights still zero
    apply_reset();                                     // flush the idle words
    configure(2'd0);                                   // int8
    run_stream(n_words, 0, '0);
    apply_reset();
    configure(2'd1);                                   // int16, lane top bits forced first
    run_stream(4, 0, {4{16'h8000}});
    run_stream(n_words - 4, 0, '0);
    apply_reset();
    configure(2'd2);                                   // int32
    run_stream(n_words, 0, '0);
    apply_reset();
    configure(2'd0);                                   // int8 with enable gaps
    run_stream(n_words, 1, '0);
    tick();
    tick();

    $display("checks %0d, sum_o errors %0d, data_o errors %0d, hold errors %0d",
             n_checks, sum_errs, data_errs, hold_errs);
    if (sum_errs + data_errs + hold_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // ends a run that stops making progress
  initial begin
    #(watchdog_ns);
    $display("timeout after %0d ns, stimulus did not finish", watchdog_ns);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
hw/smul_pkg.sv
hw/mac_config_regs.sv
hw/smul_cell.sv
hw/lane_sum_tree.sv
hw/smul_row.sv
sim/smul_row_tb.sv
